// File: fp16_vec_compare.f
+incdir+source
source/fp16_cmp_pkg.sv
source/fp16_decomp.sv
source/fp16_compare.sv
source/operand_feeder.sv
source/flag_collector.sv
source/fp16_vec_compare.sv
dv/tb_fp16_vec_compare.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_fp16_vec_compare
FILELIST  ?= fp16_vec_compare.f
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# pass only if the testbench printed the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/tb_fp16_vec_compare.sv
/* fp16 vector compare testbench */

`timescale 1ns/1ps
`include "fp16_cmp_defines.svh"
`default_nettype none

module tb_fp16_vec_compare;

	import fp16_cmp_pkg::*;

	localparam int RAND_VECS = 200;
	// directed steps plus one possible gap per random vector
	localparam int MAX_CYCLES = 5 + 100 + 2 * RAND_VECS;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic clr_flags;
	fp16_pair_t [`FP16_LANES-1:0] in_ops;
	logic out_valid;
	cmp_flags_t [`FP16_LANES-1:0] out_flags;
	logic [`FP16_LANES-1:0] unord_mask;
	logic nan_sticky;
	logic snan_sticky;

	// expected results are written by stimulus and walked by the compare process
	lane_result_t [`FP16_LANES-1:0] exp_q [$];
	int due_q [$];
	int rd_idx = 0;
	int cyc = 0;
	logic clr_q = 1'b0;
	int err_count = 0;
	int check_count = 0;
	int err_mark = 0;
	int tests_run = 0;
	integer seed = 65;

	fp16_pair_t [`FP16_LANES-1:0] v;
	fp16_pair_t [`FP16_LANES-1:0] idle_ops;
	lane_result_t [`FP16_LANES-1:0] exp_v;
	logic [`FP16_LANES-1:0] exp_mask;
	logic v_nan;
	logic v_snan;
	logic nan_m;
	logic snan_m;
	logic [31:0] pick;
	logic [15:0] a_h;
	logic [15:0] b_h;

	fp16_vec_compare dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ops      (in_ops),
		.clr_flags   (clr_flags),
		.out_valid   (out_valid),
		.out_flags   (out_flags),
		.unord_mask  (unord_mask),
		.nan_sticky  (nan_sticky),
		.snan_sticky (snan_sticky)
	);

	always #4 clk = ~clk;

	// edge counter and the clear strobe seen on each edge
	always @(posedge clk)
	begin
		cyc   <= cyc + 1;
		clr_q <= clr_flags;
	end

	// ====================
	// reference model
	// ====================

	function automatic lane_result_t ref_lane(input fp16_pair_t p);
		logic [15:0] a;
		logic [15:0] b;
		logic a_inf;
		logic a_nan;
		logic a_zero;
		logic a_sig;
		logic b_inf;
		logic b_nan;
		logic b_zero;
		logic b_sig;
		logic unord;
		logic same;
		logic mlt;
		logic mgt;
		logic lt;
		logic eq;
		lane_result_t r;
		a = p.a;
		b = p.b;
		// exponent all ones, fraction picks inf or nan
		a_inf  = (a[14:10] == 5'h1f) && (a[9:0] == 10'd0);
		a_nan  = (a[14:10] == 5'h1f) && (a[9:0] != 10'd0);
		a_zero = (a[14:0] == 15'd0);
		a_sig  = a_nan && !a[9];
		b_inf  = (b[14:10] == 5'h1f) && (b[9:0] == 10'd0);
		b_nan  = (b[14:10] == 5'h1f) && (b[9:0] != 10'd0);
		b_zero = (b[14:0] == 15'd0);
		b_sig  = b_nan && !b[9];
		unord  = a_nan || b_nan;
		same   = (a_zero && b_zero) || (a == b);
		eq     = !unord && same;
		// infinity ranks above every other magnitude
		mlt    = (a[14:0] < b[14:0]) || b_inf;
		mgt    = (a[14:0] > b[14:0]) || a_inf;
		if (a[15] != b[15])
			lt = a[15] && !(a_zero && b_zero);
		else if (a[15])
			lt = mgt;
		else
			lt = mlt;
		r = '0;
		r.flags.eq     = eq;
		r.flags.lt     = lt && !unord;
		r.flags.le     = (lt || eq) && !unord;
		r.flags.mag_lt = mlt;
		r.flags.unord  = unord;
		r.flags.ne     = !same;
		r.flags.ge     = !lt && !unord;
		r.flags.gt     = !(lt || eq) && !unord;
		r.flags.mag_ge = !mlt;
		r.flags.ord    = !unord;
		r.nan  = unord || (a_inf && b_inf);
		r.snan = a_sig || b_sig;
		return r;
	endfunction

	// ====================
	// compare tasks
	// ====================

	task automatic check_flags(input int lane, input cmp_flags_t got, input cmp_flags_t exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %0t: lane %0d condition word %h, expected %h", $time, lane, got, exp);
		end
	endtask

	task automatic check_mask(input logic [`FP16_LANES-1:0] got,
		input logic [`FP16_LANES-1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %0t: unord_mask %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_sticky(input logic [1:0] got, input logic [1:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %0t: sticky nan/snan %b, expected %b", $time, got, exp);
		end
	endtask

	// outputs are read at the falling edge, half a cycle after they settle
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			nan_m  = 1'b0;
			snan_m = 1'b0;
		end
		else
		begin
			v_nan    = 1'b0;
			v_snan   = 1'b0;
			exp_mask = '0;
			if (out_valid)
			begin
				if (rd_idx >= exp_q.size())
				begin
					err_count++;
					$display("out_valid arrived with no expected result (t=%0t)", $time);
				end
				else
				begin
					exp_v = exp_q[rd_idx];
					if (due_q[rd_idx] != cyc)
					begin
						err_count++;
						$display("out_valid not seen 3 cycles after in_valid (t=%0t)", $time);
					end
					rd_idx++;
					for (int n = 0; n < `FP16_LANES; n++)
					begin
						check_flags(n, out_flags[n], exp_v[n].flags);
						exp_mask[n] = exp_v[n].flags.unord;
						v_nan  = v_nan | exp_v[n].nan;
						v_snan = v_snan | exp_v[n].snan;
					end
				end
			end
			else if (rd_idx < due_q.size() && due_q[rd_idx] <= cyc)
			begin
				// expected vector never showed up
				err_count++;
				$display("out_valid not seen 3 cycles after in_valid (t=%0t)", $time);
				rd_idx++;
			end
			// mask is zero whenever no vector is out
			check_mask(unord_mask, exp_mask);
			// set beats a clear on the same edge
			nan_m  = (nan_m & ~clr_q) | v_nan;
			snan_m = (snan_m & ~clr_q) | v_snan;
			check_sticky({nan_sticky, snan_sticky}, {nan_m, snan_m});
		end
	end

	// ====================
	// stimulus helpers
	// ====================

	function automatic fp16_pair_t make_pair(input logic [15:0] a, input logic [15:0] b);
		fp16_pair_t p;
		p = {a, b};
		return p;
	endfunction

	// biased toward specials so nan, inf and zero lanes show up often
	function automatic logic [15:0] rand_half();
		logic [31:0] r;
		logic [15:0] h;
		r = $random(seed);
		case (r[18:16])
			3'd0:    h = {r[15], 5'h1f, r[9:0]};
			3'd1:    h = {r[15], 15'd0};
			3'd2:    h = {r[15], 5'd0, r[9:0]};
			default: h = r[15:0];
		endcase
		return h;
	endfunction

	task automatic drive(input logic valid, input fp16_pair_t [`FP16_LANES-1:0] ops,
		input logic clr);
		lane_result_t [`FP16_LANES-1:0] e;
		@(posedge clk);
		#1;
		in_valid  = valid;
		in_ops    = ops;
		clr_flags = clr;
		if (valid)
		begin
			for (int n = 0; n < `FP16_LANES; n++)
				e[n] = ref_lane(ops[n]);
			exp_q.push_back(e);
			// sampled next edge, visible after three edges
			due_q.push_back(cyc + 3);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		while (rd_idx < due_q.size())
			drive(1'b0, idle_ops, 1'b0);
		drive(1'b0, idle_ops, 1'b0);
		errs = err_count - err_mark;
		err_mark = err_count;
		tests_run++;
		if (errs == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, errs);
	endtask

	// ====================
	// test sequence
	// ====================

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		clr_flags = 1'b0;
		in_ops    = '0;
		idle_ops  = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet outputs with nothing going in
		repeat (6) drive(1'b0, idle_ops, 1'b0);
		end_test("reset");

		// mixed signs, signed zeros, equal values, subnormals, infinities
		v[0] = make_pair(16'h3c00, 16'h4000);
		v[1] = make_pair(16'hbc00, 16'h4000);
		v[2] = make_pair(16'h4000, 16'hbc00);
		v[3] = make_pair(16'hc000, 16'hbc00);
		drive(1'b1, v, 1'b0);
		v[0] = make_pair(16'h0000, 16'h8000);
		v[1] = make_pair(16'h8000, 16'h0000);
		v[2] = make_pair(16'h3c00, 16'h3c00);
		v[3] = make_pair(16'hc000, 16'hc000);
		drive(1'b1, v, 1'b0);
		v[0] = make_pair(16'h0001, 16'h0002);
		v[1] = make_pair(16'h8001, 16'h0001);
		v[2] = make_pair(16'h8002, 16'h8001);
		v[3] = make_pair(16'h0200, 16'h0000);
		drive(1'b1, v, 1'b0);
		v[0] = make_pair(16'h7c00, 16'h7bff);
		v[1] = make_pair(16'hfc00, 16'h7c00);
		v[2] = make_pair(16'hfc00, 16'hfc00);
		v[3] = make_pair(16'h7c00, 16'hfc00);
		drive(1'b1, v, 1'b0);
		end_test("ordered");

		// clear first so the quiet nan vector shows its flags alone
		drive(1'b0, idle_ops, 1'b1);
		// quiet nans 7e00 and 7e01 raise nan but leave snan low
		v[0] = make_pair(16'h7e00, 16'h3c00);
		v[1] = make_pair(16'h3c00, 16'h3c00);
		v[2] = make_pair(16'h3c00, 16'h7e01);
		v[3] = make_pair(16'h0000, 16'h8000);
		drive(1'b1, v, 1'b0);
		// signalling nans 7c01 and 7d00 have a clear fraction msb
		v[0] = make_pair(16'h3c00, 16'hbc00);
		v[1] = make_pair(16'hfe00, 16'hfe00);
		v[2] = make_pair(16'h3c00, 16'h7c01);
		v[3] = make_pair(16'h7d00, 16'h7e00);
		drive(1'b1, v, 1'b0);
		end_test("nan");

		// start clean, then a nan vector whose set lands on a clear edge
		drive(1'b0, idle_ops, 1'b1);
		drive(1'b0, idle_ops, 1'b0);
		for (int n = 0; n < `FP16_LANES; n++)
			v[n] = make_pair(16'h3c00, 16'h4000);
		v[2] = make_pair(16'h7c01, 16'h0000);
		drive(1'b1, v, 1'b0);
		v[2] = make_pair(16'h3c00, 16'h4000);
		drive(1'b1, v, 1'b0);
		drive(1'b0, idle_ops, 1'b1);
		repeat (3) drive(1'b0, idle_ops, 1'b0);
		drive(1'b0, idle_ops, 1'b1);
		drive(1'b0, idle_ops, 1'b0);
		// two infinities raise nan only
		v[1] = make_pair(16'h7c00, 16'hfc00);
		drive(1'b1, v, 1'b0);
		repeat (3) drive(1'b0, idle_ops, 1'b0);
		drive(1'b0, idle_ops, 1'b1);
		end_test("sticky");

		// back to back random vectors with the odd idle gap
		for (int k = 0; k < RAND_VECS; k++)
		begin
			pick = $random(seed);
			if (pick[3:0] == 4'd0)
				drive(1'b0, idle_ops, 1'b0);
			for (int n = 0; n < `FP16_LANES; n++)
			begin
				a_h  = rand_half();
				pick = $random(seed);
				b_h  = (pick[2:0] == 3'd0) ? a_h : rand_half();
				v[n] = make_pair(a_h, b_h);
			end
			drive(1'b1, v, 1'b0);
		end
		end_test("random");

		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
		if (err_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog sized from the longest possible run
	initial
	begin
		#((MAX_CYCLES + 20) * 8);
		$display("timeout: the run went past its cycle budget");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/fp16_vec_compare.sv
/* four-lane fp16 compare unit */

`timescale 1ns/1ps
`include "fp16_cmp_defines.svh"
`default_nettype none

module fp16_vec_compare (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        in_valid,
	input  fp16_cmp_pkg::fp16_pair_t [`FP16_LANES-1:0]  in_ops,
	input  logic                                        clr_flags,
	output logic                                        out_valid,
	output fp16_cmp_pkg::cmp_flags_t [`FP16_LANES-1:0]  out_flags,
	output logic [`FP16_LANES-1:0]                      unord_mask,
	output logic                                        nan_sticky,
	output logic                                        snan_sticky
);

	import fp16_cmp_pkg::*;

	// stage 1 to stage 2
	logic                               lane_valid;
	fp16_pair_t   [`FP16_LANES-1:0]     lane_ops;
	// stage 2 to stage 3
	logic                               lane_res_valid;
	lane_result_t [`FP16_LANES-1:0]     lane_res;

	operand_feeder u_feeder (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ops     (in_ops),
		.lane_valid (lane_valid),
		.lane_ops   (lane_ops)
	);

	// lanes run in lockstep so lane 0 carries the valid for all
	for (genvar g = 0; g < `FP16_LANES; g++)
	begin : g_lane
		if (g == 0)
		begin : g_lead
			fp16_compare u_cmp (
				.clk       (clk),
				.rst_n     (rst_n),
				.valid     (lane_valid),
				.ops       (lane_ops[g]),
				.res_valid (lane_res_valid),
				.res       (lane_res[g])
			);
		end
		else
		begin : g_follow
			fp16_compare u_cmp (
				.clk       (clk),
				.rst_n     (rst_n),
				.valid     (lane_valid),
				.ops       (lane_ops[g]),
				.res_valid (),
				.res       (lane_res[g])
			);
		end
	end

	flag_collector u_collector (
		.clk         (clk),
		.rst_n       (rst_n),
		.res_valid   (lane_res_valid),
		.clr_flags   (clr_flags),
		.lane_res    (lane_res),
		.out_valid   (out_valid),
		.out_flags   (out_flags),
		.unord_mask  (unord_mask),
		.nan_sticky  (nan_sticky),
		.snan_sticky (snan_sticky)
	);

endmodule

`default_nettype wire

// File: source/flag_collector.sv
/* result collector and sticky flags */

`timescale 1ns/1ps
`include "fp16_cmp_defines.svh"
`default_nettype none

module flag_collector (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          res_valid,
	input  logic                                          clr_flags,
	input  fp16_cmp_pkg::lane_result_t [`FP16_LANES-1:0]  lane_res,
	output logic                                          out_valid,
	output fp16_cmp_pkg::cmp_flags_t [`FP16_LANES-1:0]    out_flags,
	output logic [`FP16_LANES-1:0]                        unord_mask,
	output logic                                          nan_sticky,
	output logic                                          snan_sticky
);

	import fp16_cmp_pkg::*;

	// per-lane unord bits and exception reductions
	logic [`FP16_LANES-1:0] lane_unord;
	logic                   any_nan;
	logic                   any_snan;

	always_comb
	begin
		lane_unord = '0;
		any_nan    = 1'b0;
		any_snan   = 1'b0;
		for (int n = 0; n < `FP16_LANES; n++)
		begin
			lane_unord[n] = lane_res[n].flags.unord;
			any_nan       = any_nan | lane_res[n].nan;
			any_snan      = any_snan | lane_res[n].snan;
		end
	end

	// ====================
	// output stage
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid  <= 1'b0;
			unord_mask <= '0;
		end
		else
		begin
			out_valid  <= res_valid;
			// mask reads zero between vectors
			unord_mask <= res_valid ? lane_unord : '0;
		end
	end

	// condition words follow the valid lanes
	always_ff @(posedge clk)
	begin
		if (res_valid)
		begin
			for (int n = 0; n < `FP16_LANES; n++)
			begin
				out_flags[n] <= lane_res[n].flags;
			end
		end
	end

	// ====================
	// sticky exceptions
	// ====================

	// a new exception beats a clear on the same edge
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			nan_sticky  <= 1'b0;
			snan_sticky <= 1'b0;
		end
		else
		begin
			nan_sticky  <= (nan_sticky & ~clr_flags) | (res_valid & any_nan);
			snan_sticky <= (snan_sticky & ~clr_flags) | (res_valid & any_snan);
		end
	end

endmodule

`default_nettype wire

// File: source/operand_feeder.sv
/* operand input stage */

`timescale 1ns/1ps
`include "fp16_cmp_defines.svh"
`default_nettype none

module operand_feeder (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         in_valid,
	input  fp16_cmp_pkg::fp16_pair_t [`FP16_LANES-1:0]   in_ops,
	output logic                                         lane_valid,
	output fp16_cmp_pkg::fp16_pair_t [`FP16_LANES-1:0]   lane_ops
);

	import fp16_cmp_pkg::*;

	// ====================
	// valid strobe
	// ====================

	// one cycle behind in_valid
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			lane_valid <= 1'b0;
		else
			lane_valid <= in_valid;
	end

	// ====================
	// operand capture
	// ====================

	// pairs load on in_valid and hold while idle
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			for (int n = 0; n < `FP16_LANES; n++)
			begin
				// each lane gets its own pair slot
				lane_ops[n] <= in_ops[n];
			end
		end
	end

endmodule

`default_nettype wire

// File: source/fp16_compare.sv
/* fp16 compare lane */

`timescale 1ns/1ps
`include "fp16_cmp_defines.svh"
`default_nettype none

module fp16_compare (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       valid,
	input  fp16_cmp_pkg::fp16_pair_t   ops,
	output logic                       res_valid,
	output fp16_cmp_pkg::lane_result_t res
);

	import fp16_cmp_pkg::*;

	fp16_decomp_t da;
	fp16_decomp_t db;

	// condition word in legacy bit order
	logic [`FP16_CMP_FLAGS-1:0] word;

	logic unord;
	logic same;
	logic mag_gt;
	logic mag_lt;
	logic lt_raw;
	logic eq;

	fp16_decomp u_dec_a (.i(ops.a), .d(da));
	fp16_decomp u_dec_b (.i(ops.b), .d(db));

	// ====================
	// relations
	// ====================

	assign unord = da.nan | db.nan;
	// zeros of either sign are equal
	assign same  = (da.zero & db.zero) | (ops.a == ops.b);
	assign eq    = ~unord & same;

	// magnitude order on exp then fraction, infinity on top
	assign mag_gt = ({da.exp, da.man} > {db.exp, db.man}) | da.inf;
	assign mag_lt = ({da.exp, da.man} < {db.exp, db.man}) | db.inf;

	// signs differ: the negative one is lower unless both are zero
	// both negative: larger magnitude is lower
	assign lt_raw = (da.sign ^ db.sign) ? (da.sign & ~(da.zero & db.zero)) :
		(da.sign ? mag_gt : mag_lt);

	always_comb
	begin
		word     = '0;
		word[0]  = eq;
		word[1]  = lt_raw & ~unord;
		word[2]  = (lt_raw | eq) & ~unord;
		word[3]  = mag_lt;
		word[4]  = unord;
		// 7:5 stay reserved at zero
		word[8]  = ~same;
		word[9]  = ~lt_raw & ~unord;
		word[10] = ~(lt_raw | eq) & ~unord;
		word[11] = ~mag_lt;
		word[12] = ~unord;
	end

	// ====================
	// result register
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= valid;
	end

	// payload only loads with a live vector
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			res.flags <= cmp_flags_t'(word);
			// both infinite also raises invalid
			res.nan   <= unord | (da.inf & db.inf);
			res.snan  <= da.snan | db.snan;
		end
	end

endmodule

`default_nettype wire

// File: source/fp16_decomp.sv
/* half-precision field decoder */

`timescale 1ns/1ps
`default_nettype none

module fp16_decomp (
	input  fp16_cmp_pkg::fp16_t        i,
	output fp16_cmp_pkg::fp16_decomp_t d
);

	import fp16_cmp_pkg::*;

	// exponent extremes
	logic exp_zero;
	logic exp_ones;
	logic man_zero;

	assign exp_zero = (i.exp == 5'd0);
	assign exp_ones = (i.exp == 5'h1f);
	assign man_zero = (i.man == 10'd0);

	always_comb
	begin
		// raw fields pass straight through
		d.sign = i.sign;
		d.exp  = i.exp;
		d.man  = i.man;
		// +0 and -0 both count as zero
		d.zero = exp_zero & man_zero;
		d.inf  = exp_ones & man_zero;
		d.nan  = exp_ones & ~man_zero;
		// fraction msb picks quiet vs signalling
		d.qnan = d.nan & i.man[9];
		d.snan = d.nan & ~i.man[9];
	end

endmodule

`default_nettype wire

// File: source/fp16_cmp_pkg.sv
/* fp16 compare types */

`default_nettype none

package fp16_cmp_pkg;

	// ieee 754 binary16 value
	typedef struct packed {
		logic       sign;
		logic [4:0] exp;
		logic [9:0] man;
	} fp16_t;

	// one lane's operand pair
	typedef struct packed {
		fp16_t a;
		fp16_t b;
	} fp16_pair_t;

	// fields plus class bits of one value
	typedef struct packed {
		logic       sign;
		logic [4:0] exp;
		logic [9:0] man;
		logic       zero;
		logic       inf;
		logic       nan;
		logic       qnan;
		logic       snan;
	} fp16_decomp_t;

	// condition word, msb first, bit positions match the legacy unit
	typedef struct packed {
		logic       ord;
		logic       mag_ge;
		logic       gt;
		logic       ge;
		logic       ne;
		logic [2:0] rsvd;
		logic       unord;
		logic       mag_lt;
		logic       le;
		logic       lt;
		logic       eq;
	} cmp_flags_t;

	// what a lane hands to the collector
	typedef struct packed {
		cmp_flags_t flags;
		logic       nan;
		logic       snan;
	} lane_result_t;

endpackage

`default_nettype wire

// File: source/fp16_cmp_defines.svh
/* fp16 compare unit parameters */

`ifndef FP16_CMP_DEFINES_SVH
`define FP16_CMP_DEFINES_SVH

// ====================
// vector geometry
// ====================

// number of parallel compare lanes
`define FP16_LANES 4

// ====================
// condition word
// ====================

// eq lt le mag_lt unord, 3 reserved, ne ge gt mag_ge ord
`define FP16_CMP_FLAGS 13

`endif
